// ==== hw/afifo_pkg.sv ====
package afifo_pkg;

   // default geometry: bytes in, 32-bit words out
   localparam int def_w_data_w = 8;
   localparam int def_r_data_w = 32;

   // address width of the narrower port, 64 bytes or 16 words
   localparam int def_addr_w = 6;

   // widest pointer the gray decoder handles
   localparam int max_ptr_w = 32;

   // gray to binary over the low width bits, upper bits come back zero
   function automatic logic [max_ptr_w-1:0] gray_to_bin(
      input logic [max_ptr_w-1:0] gray,
      input int                   width
   );
      logic [max_ptr_w-1:0] bin;
      bin = '0;
      bin[width-1] = gray[width-1];
      for (int i = width - 2; i >= 0; i--) begin
         bin[i] = gray[i] ^ bin[i+1];
      end
      return bin;
   endfunction

   // log2 of wide width over narrow width, order of arguments does not matter
   function automatic int width_ratio_log2(input int a_w, input int b_w);
      int wide_w;
      int narrow_w;
      wide_w = (a_w > b_w) ? a_w : b_w;
      narrow_w = (a_w > b_w) ? b_w : a_w;
      return $clog2(wide_w / narrow_w);
   endfunction

endpackage

// ==== hw/gray_counter.sv ====
`timescale 1ns/1ns

module gray_counter #(
   parameter int width = 4
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             en,
   output logic [width-1:0] gray
);

   // binary runs one ahead of the gray copy
   logic [width-1:0] bin_q;
   logic [width-1:0] gray_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bin_q  <= width'(1);
         gray_q <= '0;
      end else if (en) begin
         bin_q  <= bin_q + 1'b1;
         // code of the value before the increment
         gray_q <= bin_q ^ (bin_q >> 1);
      end
   end

   assign gray = gray_q;

endmodule

// ==== hw/gray_ptr_sync.sv ====
`timescale 1ns/1ns

module gray_ptr_sync #(
   parameter type ptr_t = logic [3:0]
) (
   input  logic clk,
   input  logic rst,
   input  ptr_t gray_in,
   output ptr_t bin_out
);

   // two stage synchronizer for the foreign pointer
   ptr_t sync_q1;
   ptr_t sync_q2;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sync_q1 <= '0;
         sync_q2 <= '0;
      end else begin
         sync_q1 <= gray_in;
         sync_q2 <= sync_q1;
      end
   end

   // only one bit changes per step, so decoding after the second stage is safe
   assign bin_out = ptr_t'(afifo_pkg::gray_to_bin(
                       afifo_pkg::max_ptr_w'(sync_q2), $bits(ptr_t)));

endmodule

// ==== hw/asym_dp_ram.sv ====
`timescale 1ns/1ns

module asym_dp_ram #(
   parameter int w_data_w = 8,
   parameter int r_data_w = 32,
   parameter int w_addr_w = 6,
   parameter int r_addr_w = 4
) (
   input  logic                w_clk,
   input  logic                w_en,
   input  logic [w_addr_w-1:0] w_addr,
   input  logic [w_data_w-1:0] w_data,
   input  logic                r_clk,
   input  logic                r_en,
   input  logic [r_addr_w-1:0] r_addr,
   output logic [r_data_w-1:0] r_data
);

   localparam int narrow_w   = (w_data_w < r_data_w) ? w_data_w : r_data_w;
   localparam int ratio_log2 = afifo_pkg::width_ratio_log2(w_data_w, r_data_w);
   localparam int ratio      = 1 << ratio_log2;
   localparam int mem_addr_w = (w_addr_w > r_addr_w) ? w_addr_w : r_addr_w;
   localparam int depth      = 1 << mem_addr_w;

   // storage at the narrow width
   logic [narrow_w-1:0] mem [depth];

   generate
      if (w_data_w <= r_data_w) begin : g_wr_narrow
         always_ff @(posedge w_clk) begin
            if (w_en) begin
               mem[w_addr] <= w_data;
            end
         end
      end else begin : g_wr_wide
         // lowest narrow entry takes the least significant slice
         always_ff @(posedge w_clk) begin
            if (w_en) begin
               for (int i = 0; i < ratio; i++) begin
                  mem[{w_addr, ratio_log2'(i)}] <= w_data[i*narrow_w +: narrow_w];
               end
            end
         end
      end
   endgenerate

   generate
      if (r_data_w <= w_data_w) begin : g_rd_narrow
         always_ff @(posedge r_clk) begin
            if (r_en) begin
               r_data <= mem[r_addr];
            end
         end
      end else begin : g_rd_wide
         // gather ratio consecutive entries, first one lowest
         always_ff @(posedge r_clk) begin
            if (r_en) begin
               for (int i = 0; i < ratio; i++) begin
                  r_data[i*narrow_w +: narrow_w] <= mem[{r_addr, ratio_log2'(i)}];
               end
            end
         end
      end
   endgenerate

endmodule

// ==== hw/async_fifo_asym.sv ====
`timescale 1ns/1ns

module async_fifo_asym #(
   parameter int w_data_w = afifo_pkg::def_w_data_w,
   parameter int r_data_w = afifo_pkg::def_r_data_w,
   // address width of the narrower side
   parameter int addr_w   = afifo_pkg::def_addr_w,
   localparam int ratio_log2  = afifo_pkg::width_ratio_log2(w_data_w, r_data_w),
   localparam int wide_addr_w = addr_w - ratio_log2,
   localparam int w_addr_w    = (w_data_w > r_data_w) ? wide_addr_w : addr_w,
   localparam int r_addr_w    = (r_data_w > w_data_w) ? wide_addr_w : addr_w
) (
   input  logic                rst,
   input  logic                w_clk,
   input  logic                w_en,
   input  logic [w_data_w-1:0] w_data,
   output logic                w_full,
   output logic [w_addr_w-1:0] w_level,
   input  logic                r_clk,
   input  logic                r_en,
   output logic [r_data_w-1:0] r_data,
   output logic                r_empty,
   output logic [r_addr_w-1:0] r_level
);

   localparam int w_depth = 1 << w_addr_w;

   typedef logic [w_addr_w-1:0] w_ptr_t;
   typedef logic [r_addr_w-1:0] r_ptr_t;

   // write domain
   logic   w_accept;
   w_ptr_t w_ptr_gray;
   w_ptr_t w_ptr_bin;
   r_ptr_t r_ptr_sync_bin;
   w_ptr_t r_ptr_aligned;

   // read domain
   logic   r_accept;
   r_ptr_t r_ptr_gray;
   r_ptr_t r_ptr_bin;
   w_ptr_t w_ptr_sync_bin;
   r_ptr_t w_ptr_aligned;

   assign w_accept = w_en & ~w_full;
   assign r_accept = r_en & ~r_empty;

   gray_counter #(
      .width(w_addr_w)
   ) u_w_ptr (
      .clk  (w_clk),
      .rst  (rst),
      .en   (w_accept),
      .gray (w_ptr_gray)
   );

   gray_counter #(
      .width(r_addr_w)
   ) u_r_ptr (
      .clk  (r_clk),
      .rst  (rst),
      .en   (r_accept),
      .gray (r_ptr_gray)
   );

   // own pointers in binary, also the RAM addresses
   assign w_ptr_bin = w_addr_w'(afifo_pkg::gray_to_bin(
                         afifo_pkg::max_ptr_w'(w_ptr_gray), w_addr_w));
   assign r_ptr_bin = r_addr_w'(afifo_pkg::gray_to_bin(
                         afifo_pkg::max_ptr_w'(r_ptr_gray), r_addr_w));

   // read pointer into the write domain
   gray_ptr_sync #(
      .ptr_t(r_ptr_t)
   ) u_r_ptr_sync (
      .clk     (w_clk),
      .rst     (rst),
      .gray_in (r_ptr_gray),
      .bin_out (r_ptr_sync_bin)
   );

   // write pointer into the read domain
   gray_ptr_sync #(
      .ptr_t(w_ptr_t)
   ) u_w_ptr_sync (
      .clk     (r_clk),
      .rst     (rst),
      .gray_in (w_ptr_gray),
      .bin_out (w_ptr_sync_bin)
   );

   // bring foreign pointers to the local unit
   // dropping the low bits hides a partly written wide word
   generate
      if (w_addr_w > r_addr_w) begin : g_align_up
         assign r_ptr_aligned = {r_ptr_sync_bin, {ratio_log2{1'b0}}};
         assign w_ptr_aligned = w_ptr_sync_bin[w_addr_w-1:ratio_log2];
      end else if (w_addr_w == r_addr_w) begin : g_align_same
         assign r_ptr_aligned = r_ptr_sync_bin;
         assign w_ptr_aligned = w_ptr_sync_bin;
      end else begin : g_align_down
         assign r_ptr_aligned = r_ptr_sync_bin[r_addr_w-1:ratio_log2];
         assign w_ptr_aligned = {w_ptr_sync_bin, {ratio_log2{1'b0}}};
      end
   endgenerate

   // levels wrap modulo the pointer width
   assign w_level = w_ptr_bin - r_ptr_aligned;
   assign r_level = w_ptr_aligned - r_ptr_bin;

   // one narrow slot stays free so full and empty never alias
   assign w_full  = (w_level == w_addr_w'(w_depth - 1));
   assign r_empty = (r_level == '0);

   asym_dp_ram #(
      .w_data_w (w_data_w),
      .r_data_w (r_data_w),
      .w_addr_w (w_addr_w),
      .r_addr_w (r_addr_w)
   ) u_ram (
      .w_clk  (w_clk),
      .w_en   (w_accept),
      .w_addr (w_ptr_bin),
      .w_data (w_data),
      .r_clk  (r_clk),
      .r_en   (r_accept),
      .r_addr (r_ptr_bin),
      .r_data (r_data)
   );

endmodule

// ==== hw/cdc_upsize_fifo.sv ====
`timescale 1ns/1ns

module cdc_upsize_fifo #(
   parameter int w_data_w = afifo_pkg::def_w_data_w,
   parameter int r_data_w = afifo_pkg::def_r_data_w,
   parameter int addr_w   = afifo_pkg::def_addr_w,
   localparam int ratio_log2  = afifo_pkg::width_ratio_log2(w_data_w, r_data_w),
   localparam int wide_addr_w = addr_w - ratio_log2,
   localparam int w_addr_w    = (w_data_w > r_data_w) ? wide_addr_w : addr_w,
   localparam int r_addr_w    = (r_data_w > w_data_w) ? wide_addr_w : addr_w
) (
   input  logic                rst,

   // write side, bytes in
   input  logic                w_clk,
   input  logic [w_data_w-1:0] w_data,
   input  logic                w_en,
   output logic                w_full,
   output logic [w_addr_w-1:0] w_level,

   // read side, words out
   input  logic                r_clk,
   output logic [r_data_w-1:0] r_data,
   input  logic                r_en,
   output logic                r_empty,
   output logic [r_addr_w-1:0] r_level
);

   async_fifo_asym #(
      .w_data_w (w_data_w),
      .r_data_w (r_data_w),
      .addr_w   (addr_w)
   ) u_fifo (
      .rst     (rst),
      .w_clk   (w_clk),
      .w_en    (w_en),
      .w_data  (w_data),
      .w_full  (w_full),
      .w_level (w_level),
      .r_clk   (r_clk),
      .r_en    (r_en),
      .r_data  (r_data),
      .r_empty (r_empty),
      .r_level (r_level)
   );

endmodule

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/1ns

module tb_clkgen #(
   parameter int period = 8
) (
   output logic clk
);

   // free running, starts low
   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

endmodule

// ==== tb/tb_checker.sv ====
`timescale 1ns/1ns

module tb_checker #(
   parameter int w_data_w = 8,
   parameter int r_data_w = 32
) (
   input  logic                rst,
   input  logic                w_clk,
   input  logic                w_en,
   input  logic [w_data_w-1:0] w_data,
   input  logic                w_full,
   input  logic                r_clk,
   input  logic                r_en,
   input  logic                r_empty,
   input  logic [r_data_w-1:0] r_data
);

   localparam int ratio = r_data_w / w_data_w;

   // reference model, accepted bytes in write order
   logic [w_data_w-1:0] byte_q [$];
   logic [r_data_w-1:0] exp_word;
   logic                word_due = 1'b0;
   string               cur_test = "none";
   int                  r_errors = 0;
   int                  call_errors = 0;
   int                  r_checks = 0;
   int                  call_checks = 0;
   int                  drops_total = 0;
   int                  words_total = 0;
   int                  drops_at_start = 0;
   int                  words_at_start = 0;
   int                  errors_at_start = 0;
   int                  tests_run = 0;

   always @(posedge w_clk) begin
      if (!rst && w_en) begin
         if (!w_full) begin
            byte_q.push_back(w_data);
         end else begin
            drops_total++;
         end
      end
   end

   always @(posedge r_clk) begin
      // word from the previous accepted read is now on r_data
      if (word_due) begin
         r_checks++;
         if (r_data !== exp_word) begin
            r_errors++;
            $display("FAIL %s word %0d: expected %h, actual %h", cur_test,
                     words_total - words_at_start, exp_word, r_data);
         end
         word_due = 1'b0;
      end
      if (!rst && r_en && !r_empty) begin
         words_total++;
         if (byte_q.size() < ratio) begin
            r_errors++;
            $display("%s: word read while only %0d bytes were written", cur_test,
                     byte_q.size());
            byte_q.delete();
         end else begin
            // first byte lands lowest
            for (int i = 0; i < ratio; i++) begin
               exp_word[i*w_data_w +: w_data_w] = byte_q.pop_front();
            end
            word_due = 1'b1;
         end
      end
   end

   function automatic int total_errors();
      return r_errors + call_errors;
   endfunction

   function automatic int drops_in_test();
      return drops_total - drops_at_start;
   endfunction

   function automatic int queued_bytes();
      return byte_q.size();
   endfunction

   task automatic begin_test(input string name);
      cur_test = name;
      drops_at_start = drops_total;
      words_at_start = words_total;
      errors_at_start = total_errors();
   endtask

   task automatic check_value(input string what, input int exp, input int act);
      call_checks++;
      if (exp != act) begin
         call_errors++;
         $display("FAIL %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      end
   endtask

   task automatic end_test();
      tests_run++;
      if (total_errors() == errors_at_start) begin
         $display("test %s: ok", cur_test);
      end else begin
         $display("test %s: %0d errors", cur_test, total_errors() - errors_at_start);
      end
   endtask

   task automatic report_counts();
      $display("tests %0d, checks %0d, errors %0d", tests_run,
               r_checks + call_checks, total_errors());
   endtask

endmodule

// ==== tb/fifo_properties.sv ====
`timescale 1ns/1ns

module fifo_properties #(
   parameter int w_lvl_w  = 6,
   parameter int r_data_w = 32
) (
   input logic                rst,
   input logic                w_clk,
   input logic                r_clk,
   input logic                w_accept,
   input logic                w_full,
   input logic [w_lvl_w-1:0]  w_level,
   input logic                r_empty,
   input logic [r_data_w-1:0] r_data
);

   int failures = 0;

   // an attempt while full leaves the level where it was or lower
   no_write_when_full: assert property (
      @(posedge w_clk) disable iff (rst) w_full |=> w_level <= $past(w_level))
      else begin
         $error("w_level rose after a write attempt while w_full was high");
         failures++;
      end

   // a write past full would wrap the level to zero
   level_no_wrap: assert property (
      @(posedge w_clk) disable iff (rst) w_accept |=> w_level != '0)
      else begin
         $error("w_level wrapped to zero after an accepted write");
         failures++;
      end

   // last word stays on r_data while empty
   data_held_when_empty: assert property (
      @(posedge r_clk) disable iff (rst) r_empty |=> r_data === $past(r_data))
      else begin
         $error("r_data changed after a read attempt while r_empty was high");
         failures++;
      end

endmodule

// ==== tb/tb_top.sv ====
`timescale 1ns/1ns

module tb_top;

   localparam int w_data_w = 8;
   localparam int r_data_w = 32;
   localparam int addr_w   = 6;
   localparam int r_lvl_w  = 4;
   localparam int n_tests  = 6;
   localparam logic [31:0] seed = 32'he067_39fe;

   // one row of the test table
   typedef struct packed {
      int   n_wr;
      int   n_rd;
      int   wr_pct;
      int   rd_pct;
      logic rd_after_wr;
      logic wr_blind;
      int   exp_drops;
      int   exp_w_level;
   } test_row_t;

   // bytes, words, enable odds in percent, reads after writes, writes ignore full,
   // then dropped writes and bytes left over once both sides are idle
   test_row_t tests [n_tests] = '{
      '{32,   8,  100, 100, 1'b1, 1'b0, 0, 0},
      '{70,   15, 100, 100, 1'b1, 1'b1, 7, 3},
      '{1,    1,  100, 100, 1'b1, 1'b0, 0, 0},
      '{3,    0,  100, 100, 1'b1, 1'b0, 0, 3},
      '{1,    1,  100, 100, 1'b1, 1'b0, 0, 0},
      '{400,  100, 70, 20,  1'b0, 1'b0, 0, 0}
   };
   string test_names [n_tests] = '{"burst_32", "fill_drop", "drain_tail", "partial_3",
                                   "fourth_byte", "random_400"};

   logic                rst;
   logic                w_clk;
   logic                r_clk;
   logic [w_data_w-1:0] w_data;
   logic                w_en;
   logic                w_full;
   logic [addr_w-1:0]   w_level;
   logic [r_data_w-1:0] r_data;
   logic                r_en;
   logic                r_empty;
   logic [r_lvl_w-1:0]  r_level;
   int                  timeout_limit = 0;
   int                  cycles = 0;

   tb_clkgen #(.period(8)) u_w_clk (.clk(w_clk));
   tb_clkgen #(.period(12)) u_r_clk (.clk(r_clk));

   cdc_upsize_fifo #(
      .w_data_w (w_data_w),
      .r_data_w (r_data_w),
      .addr_w   (addr_w)
   ) DUT (
      .rst     (rst),
      .w_clk   (w_clk),
      .w_data  (w_data),
      .w_en    (w_en),
      .w_full  (w_full),
      .w_level (w_level),
      .r_clk   (r_clk),
      .r_data  (r_data),
      .r_en    (r_en),
      .r_empty (r_empty),
      .r_level (r_level)
   );

   tb_checker #(
      .w_data_w (w_data_w),
      .r_data_w (r_data_w)
   ) u_checker (
      .rst     (rst),
      .w_clk   (w_clk),
      .w_en    (w_en),
      .w_data  (w_data),
      .w_full  (w_full),
      .r_clk   (r_clk),
      .r_en    (r_en),
      .r_empty (r_empty),
      .r_data  (r_data)
   );

   bind async_fifo_asym fifo_properties #(
      .w_lvl_w  (w_addr_w),
      .r_data_w (r_data_w)
   ) u_props (
      .rst      (rst),
      .w_clk    (w_clk),
      .r_clk    (r_clk),
      .w_accept (w_accept),
      .w_full   (w_full),
      .w_level  (w_level),
      .r_empty  (r_empty),
      .r_data   (r_data)
   );

   function automatic int total_bytes();
      int sum;
      sum = 0;
      for (int i = 0; i < n_tests; i++) begin
         sum += tests[i].n_wr;
      end
      return sum;
   endfunction

   // w_full only moves on w_clk edges, so the value seen here holds at the next edge
   task automatic run_writes(input int n, input int pct, input bit blind);
      int sent;
      sent = 0;
      while (sent < n) begin
         @(posedge w_clk);
         #1;
         if ($urandom_range(0, 99) < pct && (blind || !w_full)) begin
            w_en = 1'b1;
            w_data = w_data_w'($urandom);
            sent++;
         end else begin
            w_en = 1'b0;
         end
      end
      @(posedge w_clk);
      #1;
      w_en = 1'b0;
   endtask

   // r_en while empty is driven too and must be ignored
   task automatic run_reads(input int n, input int pct);
      int got;
      got = 0;
      while (got < n) begin
         @(posedge r_clk);
         #1;
         r_en = ($urandom_range(0, 99) < pct);
         if (r_en && !r_empty) begin
            got++;
         end
      end
      @(posedge r_clk);
      #1;
      r_en = 1'b0;
   endtask

   initial begin
      test_row_t row;
      rst = 1'b1;
      w_en = 1'b0;
      w_data = '0;
      r_en = 1'b0;
      void'($urandom(seed));
      timeout_limit = 20 * total_bytes();
      repeat (10) @(posedge w_clk);
      #1;
      rst = 1'b0;
      u_checker.begin_test("reset_state");
      u_checker.check_value("r_empty", 1, int'(r_empty));
      u_checker.check_value("w_full", 0, int'(w_full));
      u_checker.check_value("w_level", 0, int'(w_level));
      u_checker.check_value("r_level", 0, int'(r_level));
      u_checker.end_test();
      for (int t = 0; t < n_tests; t++) begin
         row = tests[t];
         u_checker.begin_test(test_names[t]);
         if (row.rd_after_wr) begin
            run_writes(row.n_wr, row.wr_pct, row.wr_blind);
            run_reads(row.n_rd, row.rd_pct);
         end else begin
            fork
               run_writes(row.n_wr, row.wr_pct, row.wr_blind);
               run_reads(row.n_rd, row.rd_pct);
            join
         end
         // a row without reads leaves a partial word, never readable
         repeat (20) begin
            @(posedge r_clk);
            #1;
            if (row.n_rd == 0) begin
               u_checker.check_value("r_empty with partial word", 1, int'(r_empty));
            end
         end
         u_checker.check_value("dropped writes", row.exp_drops, u_checker.drops_in_test());
         u_checker.check_value("queued bytes", row.exp_w_level, u_checker.queued_bytes());
         u_checker.check_value("w_level", row.exp_w_level, int'(w_level));
         u_checker.check_value("r_empty", 1, int'(r_empty));
         u_checker.end_test();
      end
      u_checker.begin_test("final_idle");
      repeat (10) @(posedge r_clk);
      #1;
      u_checker.check_value("queued bytes", 0, u_checker.queued_bytes());
      u_checker.check_value("r_empty", 1, int'(r_empty));
      u_checker.check_value("w_level", 0, int'(w_level));
      u_checker.end_test();
      u_checker.report_counts();
      if (u_checker.total_errors() == 0 && DUT.u_fifo.u_props.failures == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // run limit in write clock cycles
   initial begin
      wait (timeout_limit > 0);
      while (cycles < timeout_limit) begin
         @(posedge w_clk);
         cycles++;
      end
      $display("timeout: tests did not finish within %0d write clock cycles", timeout_limit);
      $display("Errors found");
      $finish;
   end

endmodule

// ==== filelist.f ====
hw/afifo_pkg.sv
hw/gray_counter.sv
hw/gray_ptr_sync.sv
hw/asym_dp_ram.sv
hw/async_fifo_asym.sv
hw/cdc_upsize_fifo.sv
tb/tb_clkgen.sv
tb/tb_checker.sv
tb/fifo_properties.sv
tb/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cdc fifo testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
   --top-module tb_top -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_top)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "No errors"; then
   echo "simulation passed"
   exit 0
fi

echo "simulation failed"
exit 1
